//--- book_update.f
hdl/book_pkg.sv
hdl/book_if.sv
hdl/book_match.sv
hdl/book_ctrl.sv
hdl/book_shift.sv
hdl/book_notify.sv
hdl/book_top.sv
dv/book_top_sva.sv
dv/tb_book.sv

//--- Makefile
# Verilator flow for the price-ordered book

TOOL      = verilator
TOP       = tb_book
FILELIST  = book_update.f
BUILD_DIR = obj_dir
COMMON    = --timing --assert --top-module $(TOP) -f $(FILELIST)
LINTFLAGS = --lint-only $(COMMON)
SIMFLAGS  = --binary -j 0 --Mdir $(BUILD_DIR) $(COMMON)
PASS_MSG  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS)

sim:
	$(TOOL) $(SIMFLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_book.sv
/*
  Book testbench
  Directed tests of the price-ordered book against a queue model
  kept sorted largest key first, with clock, reset, timeout and
  a closing report
*/
module tb_book
  import book_pkg::*;
();

  localparam int SEED           = 32'h0630_aa56;
  localparam int CLK_HALF       = 10;
  localparam int RESET_CYCLES   = 8;
  // Each command takes a strobe cycle and an idle cycle
  localparam int CYCLES_PER_CMD = 2;
  // Upper bound on commands issued by all tests
  localparam int CMD_BUDGET     = 46;
  // Four times the expected run, 400 cycles
  localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + CYCLES_PER_CMD * CMD_BUDGET);

  logic      clk;
  logic      rst_n;
  logic      cmd_vld;
  cmd_t      cmd;
  key_t      key;
  volume_t   volume;
  listsize_t listsize;
  logic      head_vld;
  key_t      head_key;
  volume_t   head_volume;
  logic      notify_vld;
  key_t      notify_key;
  volume_t   notify_volume;

  // Reference model, index 0 is the head
  key_t    mdl_keys [$];
  volume_t mdl_vols [$];
  // Expected notify for the last command
  logic    exp_notify;
  key_t    exp_nkey;
  volume_t exp_nvol;

  int err_cnt;
  int check_cnt;
  int cycle_cnt;

  book_top book_top_inst (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_cmd_vld       (cmd_vld),
    .i_cmd           (cmd),
    .i_key           (key),
    .i_volume        (volume),
    .o_listsize      (listsize),
    .o_head_vld      (head_vld),
    .o_head_key      (head_key),
    .o_head_volume   (head_volume),
    .o_notify_vld    (notify_vld),
    .o_notify_key    (notify_key),
    .o_notify_volume (notify_volume)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // Position of a key in the model, -1 when absent
  function automatic int find_key(input key_t k);
    foreach (mdl_keys[i]) begin
      if (mdl_keys[i] == k) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Apply one command to the model and work out the notify
  task automatic model_apply(input cmd_t c, input key_t k, input volume_t v);
    int pos;
    int idx;
    exp_notify = 1'b0;
    exp_nkey   = k;
    exp_nvol   = '0;
    idx        = find_key(k);
    case (c)
      CMD_ADD: begin
        pos = 0;
        while (pos < mdl_keys.size() && mdl_keys[pos] > k) begin
          pos++;
        end
        // Below the tail of a full book nothing lands
        if (pos < ENTRIES_N) begin
          mdl_keys.insert(pos, k);
          mdl_vols.insert(pos, v);
          if (mdl_keys.size() > ENTRIES_N) begin
            void'(mdl_keys.pop_back());
            void'(mdl_vols.pop_back());
          end
          exp_notify = (pos == 0);
          exp_nvol   = v;
        end
      end
      CMD_DELETE: begin
        if (idx >= 0) begin
          exp_notify = (idx == 0);
          exp_nvol   = mdl_vols[idx];
          mdl_keys.delete(idx);
          mdl_vols.delete(idx);
        end
      end
      CMD_REPLACE: begin
        if (idx >= 0) begin
          mdl_vols[idx] = v;
          exp_notify    = (idx == 0);
          exp_nvol      = v;
        end
      end
      default: begin
        // CLEAR reports volume zero only when something was removed
        exp_notify = (mdl_keys.size() > 0);
        mdl_keys.delete();
        mdl_vols.delete();
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_cnt++;
    assert (act_val === exp_val) else begin
      $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic check_outputs();
    check_value("o_listsize", 32'(mdl_keys.size()), 32'(listsize));
    check_value("o_head_vld", 32'(mdl_keys.size() > 0), 32'(head_vld));
    // Head payload is stale once the book is empty
    if (mdl_keys.size() > 0) begin
      check_value("o_head_key", 32'(mdl_keys[0]), 32'(head_key));
      check_value("o_head_volume", 32'(mdl_vols[0]), 32'(head_volume));
    end
    check_value("o_notify_vld", 32'(exp_notify), 32'(notify_vld));
    if (exp_notify) begin
      check_value("o_notify_key", 32'(exp_nkey), 32'(notify_key));
      check_value("o_notify_volume", 32'(exp_nvol), 32'(notify_volume));
    end
  endtask

  // One strobe, then compare half a cycle after the update edge
  task automatic send_cmd(input cmd_t c, input key_t k, input volume_t v);
    @(posedge clk);
    cmd_vld <= 1'b1;
    cmd     <= c;
    key     <= k;
    volume  <= v;
    @(posedge clk);
    cmd_vld <= 1'b0;
    model_apply(c, k, v);
    @(negedge clk);
    check_outputs();
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s: %0d errors", name, err_cnt - err_start);
  endtask

  // Empty after reset, then adds that each land at the tail
  task automatic descending_adds();
    int err_start;
    err_start  = err_cnt;
    exp_notify = 1'b0;
    @(negedge clk);
    check_outputs();
    for (int i = 0; i < 6; i++) begin
      send_cmd(CMD_ADD, key_t'(16'h9000 - i * 16'h0800), volume_t'(16'h0100 + i));
    end
    report_test("descending_adds", err_start);
  endtask

  // Distinct random keys, head must always be the largest
  task automatic random_adds();
    int   err_start;
    key_t k;
    err_start = err_cnt;
    send_cmd(CMD_CLEAR, key_t'($urandom), '0);
    for (int i = 0; i < 10; i++) begin
      do begin
        k = key_t'($urandom);
      end while (find_key(k) >= 0);
      send_cmd(CMD_ADD, k, volume_t'($urandom));
    end
    report_test("random_adds", err_start);
  endtask

  // Fill the book out of order, then push past capacity
  task automatic full_book_adds();
    int   err_start;
    key_t order [ENTRIES_N];
    err_start = err_cnt;
    order     = '{16'd400, 16'd800, 16'd100, 16'd600, 16'd300, 16'd700, 16'd200, 16'd500};
    send_cmd(CMD_CLEAR, 16'd1, '0);
    foreach (order[i]) begin
      send_cmd(CMD_ADD, order[i], volume_t'(order[i] + 16'd1));
    end
    // Inner insert drops 100, low key is lost, new head drops 200
    send_cmd(CMD_ADD, 16'd450, 16'h0451);
    send_cmd(CMD_ADD, 16'd50, 16'h0051);
    send_cmd(CMD_ADD, 16'd900, 16'h0901);
    report_test("full_book_adds", err_start);
  endtask

  task automatic head_and_inner_deletes();
    int err_start;
    err_start = err_cnt;
    send_cmd(CMD_DELETE, 16'd900, '0);
    send_cmd(CMD_DELETE, 16'd600, '0);
    // Missing key keeps the size
    send_cmd(CMD_DELETE, 16'd1234, '0);
    send_cmd(CMD_DELETE, 16'd300, '0);
    send_cmd(CMD_DELETE, 16'd450, '0);
    report_test("head_and_inner_deletes", err_start);
  endtask

  task automatic replace_volumes();
    int err_start;
    err_start = err_cnt;
    send_cmd(CMD_REPLACE, 16'd800, 16'hbeef);
    send_cmd(CMD_REPLACE, 16'd700, 16'h7777);
    send_cmd(CMD_REPLACE, 16'd999, 16'h1111);
    // Deleting heads exposes the replaced inner volume
    send_cmd(CMD_DELETE, 16'd800, '0);
    send_cmd(CMD_DELETE, 16'd700, '0);
    report_test("replace_volumes", err_start);
  endtask

  task automatic clear_book();
    int err_start;
    err_start = err_cnt;
    send_cmd(CMD_CLEAR, 16'h00c1, 16'h5a5a);
    send_cmd(CMD_CLEAR, 16'h00c2, 16'h0000);
    report_test("clear_book", err_start);
  endtask

  initial begin
    err_cnt   = 0;
    check_cnt = 0;
    void'($urandom(SEED));
    rst_n     <= 1'b0;
    cmd_vld   <= 1'b0;
    cmd       <= CMD_CLEAR;
    key       <= '0;
    volume    <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    descending_adds();
    random_adds();
    full_book_adds();
    head_and_inner_deletes();
    replace_volumes();
    clear_book();
    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog on the whole run
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d cycles", cycle_cnt);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- dv/book_top_sva.sv
/*
  Book top-level checks
  Concurrent assertions on list size, notify pulse width and
  head validity, bound into every book_top instance
*/
module book_top_sva
  import book_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_cmd_vld,
  input listsize_t o_listsize,
  input logic      o_head_vld,
  input logic      o_notify_vld
);

  // Size counter stays within the number of positions
  a_size_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    int'(o_listsize) <= ENTRIES_N)
    else $error("list size above book capacity");

  // Notify needs a strobe at each edge to stay high
  a_notify_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_notify_vld && !i_cmd_vld) |=> !o_notify_vld)
    else $error("notify held high without a new command");

  // Head valid tracks a non-empty book
  a_head_vld: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_head_vld == (o_listsize != '0))
    else $error("head valid disagrees with list size");

endmodule

bind book_top book_top_sva book_top_sva_inst (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_cmd_vld    (i_cmd_vld),
  .o_listsize   (o_listsize),
  .o_head_vld   (o_head_vld),
  .o_notify_vld (o_notify_vld)
);

//--- hdl/book_top.sv
/*
  Book top level
  Price-ordered book of up to ENTRIES_N entries, largest key at
  the head. One command per cycle, one cycle to state and notify
*/
module book_top
  import book_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_cmd_vld,
  input  cmd_t      i_cmd,
  input  key_t      i_key,
  input  volume_t   i_volume,
  output listsize_t o_listsize,
  output logic      o_head_vld,
  output key_t      o_head_key,
  output volume_t   o_head_volume,
  output logic      o_notify_vld,
  output key_t      o_notify_key,
  output volume_t   o_notify_volume
);

  book_cmp_if   cmp_if ();
  book_shift_if sh_if ();

  // Stored book state
  key_t       keys    [ENTRIES_N];
  volume_t    volumes [ENTRIES_N];
  entry_vec_t vld;

  assign o_head_vld    = vld[0];
  assign o_head_key    = keys[0];
  assign o_head_volume = volumes[0];

  book_match u_match (
    .i_cmd_key (i_key),
    .i_keys    (keys),
    .i_vld     (vld),
    .cmp       (cmp_if.src)
  );

  book_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cmd_vld  (i_cmd_vld),
    .i_cmd      (i_cmd),
    .cmp        (cmp_if.dst),
    .sh         (sh_if.ctrl),
    .o_vld      (vld),
    .o_listsize (o_listsize)
  );

  // Key column
  book_shift #(.payload_t(key_t)) u_key_col (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_data    (i_key),
    .sh        (sh_if.col),
    .i_use_key (1'b1),
    .o_col     (keys)
  );

  // Volume column
  book_shift #(.payload_t(volume_t)) u_vol_col (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_data    (i_volume),
    .sh        (sh_if.col),
    .i_use_key (1'b0),
    .o_col     (volumes)
  );

  book_notify u_notify (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_cmd_vld       (i_cmd_vld),
    .i_cmd           (i_cmd),
    .i_key           (i_key),
    .i_volume        (i_volume),
    .i_vld0          (vld[0]),
    .i_match_sel0    (cmp_if.sel[0]),
    .i_ins0          (sh_if.ins_key[0]),
    .i_head_volume   (volumes[0]),
    .sh              (sh_if.mon),
    .o_notify_vld    (o_notify_vld),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume)
  );

endmodule

//--- hdl/book_notify.sv
/*
  Book head notify
  Detects a change of the head entry and registers a one-cycle
  notify pulse with the command key and the head volume
*/
module book_notify
  import book_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_cmd_vld,
  input  cmd_t      i_cmd,
  input  key_t      i_key,
  input  volume_t   i_volume,
  input  logic      i_vld0,
  input  logic      i_match_sel0,
  input  logic      i_ins0,
  input  volume_t   i_head_volume,
  book_shift_if.mon sh,
  output logic      o_notify_vld,
  output key_t      o_notify_key,
  output volume_t   o_notify_volume
);

  logic    op_clr;
  logic    op_add;
  logic    op_del;
  logic    op_rep;
  logic    fire;
  volume_t vol_nxt;

  assign op_clr = i_cmd_vld && (i_cmd == CMD_CLEAR);
  assign op_add = i_cmd_vld && (i_cmd == CMD_ADD);
  assign op_del = i_cmd_vld && (i_cmd == CMD_DELETE);
  assign op_rep = i_cmd_vld && (i_cmd == CMD_REPLACE);

  // Clear of a non-empty book, new head, or head deleted/replaced
  assign fire = (op_clr & i_vld0) | (op_add & i_ins0) |
                ((op_del | op_rep) & i_match_sel0);

  // New volume written to head, else removed head volume
  // CLEAR reports zero
  always_comb begin
    if (sh.ins_vol[0]) begin
      vol_nxt = i_volume;
    end else if (sh.take_left[0]) begin
      vol_nxt = i_head_volume;
    end else begin
      vol_nxt = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_notify_vld <= 1'b0;
    end else begin
      o_notify_vld <= fire;
    end
  end

  // Message payload, held between notifies
  always_ff @(posedge i_clk) begin
    if (fire) begin
      o_notify_key    <= i_key;
      o_notify_volume <= vol_nxt;
    end
  end

endmodule

//--- hdl/book_shift.sv
/*
  Book payload column
  One register per position; each takes the new item, a
  neighbour's item, or holds. Used for keys and for volumes
*/
module book_shift
  import book_pkg::*;
#(
  parameter type payload_t = key_t
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  payload_t  i_data,
  book_shift_if.col sh,
  input  logic      i_use_key,
  output payload_t  o_col [ENTRIES_N]
);

  entry_vec_t ins;
  entry_vec_t wr;

  // Key column follows ins_key, volume column follows ins_vol
  assign ins = i_use_key ? sh.ins_key : sh.ins_vol;
  assign wr  = ins | sh.take_left | sh.take_right;

  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_pos
    payload_t from_lo;
    payload_t from_hi;
    payload_t nxt;

    // Edge positions have one neighbour, the missing one is self
    if (i == 0) begin : g_head
      assign from_lo = o_col[i];
    end else begin : g_lo
      assign from_lo = o_col[i-1];
    end

    if (i == ENTRIES_N - 1) begin : g_tail
      assign from_hi = o_col[i];
    end else begin : g_hi
      assign from_hi = o_col[i+1];
    end

    // Controls are mutually exclusive per position
    assign nxt = ins[i]           ? i_data :
                 sh.take_right[i] ? from_lo :
                                    from_hi;

    always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
        o_col[i] <= '0;
      end else if (sh.upd && wr[i]) begin
        o_col[i] <= nxt;
      end
    end
  end

endmodule

//--- hdl/book_ctrl.sv
/*
  Book control
  Decodes commands, plans the insert and shift masks for the
  payload columns, and holds the validity vector and list size
*/
module book_ctrl
  import book_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_cmd_vld,
  input  cmd_t       i_cmd,
  book_cmp_if.dst    cmp,
  book_shift_if.ctrl sh,
  output entry_vec_t o_vld,
  output listsize_t  o_listsize
);

  logic       op_add;
  logic       op_del;
  logic       op_rep;
  entry_vec_t ins_pos;
  entry_vec_t ins_mask;
  entry_vec_t add_sel;
  entry_vec_t add_shift;
  entry_vec_t del_mask;
  entry_vec_t vld_nxt;
  listsize_t  listsize_nxt;

  // Opcode decode, masks are qualified by upd in the columns
  assign op_add = (i_cmd == CMD_ADD);
  assign op_del = (i_cmd == CMD_DELETE);
  assign op_rep = (i_cmd == CMD_REPLACE);

  // Insertion point is the lowest zero of cmp
  // All ones (full, key below tail) gives no insert
  assign ins_pos  = ~cmp.cmp & (cmp.cmp + entry_vec_t'(1));

  // Positions at and above the insertion point
  assign ins_mask = ~(ins_pos - entry_vec_t'(1));

  // Valid entries that move one step towards the tail
  assign add_sel   = o_vld & ins_mask;
  // Top bit falls off, so a full book loses its tail
  assign add_shift = add_sel << 1;

  // Everything above the deleted entry moves towards the head
  // A miss leaves sel zero and the mask empty
  assign del_mask = ~(cmp.sel - entry_vec_t'(1));

  assign sh.take_right = op_add ? add_shift : '0;
  assign sh.take_left  = op_del ? del_mask : '0;
  assign sh.ins_key    = op_add ? ins_pos : '0;
  // REPLACE writes only the volume of the matched entry
  assign sh.ins_vol    = (op_add ? ins_pos : '0) | (op_rep ? cmp.sel : '0);
  assign sh.upd        = i_cmd_vld;

  // Next validity and size
  always_comb begin
    vld_nxt      = o_vld;
    listsize_nxt = o_listsize;
    case (i_cmd)
      CMD_CLEAR: begin
        vld_nxt      = '0;
        listsize_nxt = '0;
      end
      CMD_ADD: begin
        vld_nxt = o_vld | add_shift | ins_pos;
        // Full book keeps size, tail entry is replaced
        if (!cmp.full) begin
          listsize_nxt = o_listsize + listsize_t'(1);
        end
      end
      CMD_DELETE: begin
        if (cmp.hit) begin
          // Entries are contiguous, so drop the top valid bit
          vld_nxt      = o_vld >> 1;
          listsize_nxt = o_listsize - listsize_t'(1);
        end
      end
      default: begin
        // REPLACE leaves occupancy alone
        vld_nxt = o_vld;
      end
    endcase
  end

  // State registers, written on the edge after the strobe
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_vld      <= '0;
      o_listsize <= '0;
    end else if (i_cmd_vld) begin
      o_vld      <= vld_nxt;
      o_listsize <= listsize_nxt;
    end
  end

endmodule

//--- hdl/book_match.sv
/*
  Book match stage
  Compares the command key with every stored key in parallel and
  reports the equal entry, the greater entries and book fullness
*/
module book_match
  import book_pkg::*;
(
  input  key_t       i_cmd_key,
  input  key_t       i_keys [ENTRIES_N],
  input  entry_vec_t i_vld,
  book_cmp_if.src    cmp
);

  entry_vec_t eq;
  entry_vec_t gt;

  // One comparator pair per position
  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_cmp
    assign eq[i] = i_vld[i] && (i_keys[i] == i_cmd_key);
    assign gt[i] = i_vld[i] && (i_keys[i] > i_cmd_key);
  end

  // Keys are unique so eq is at most one-hot
  assign cmp.sel  = eq;
  assign cmp.hit  = |eq;

  // Valid entries are packed from the head, top bit set means full
  assign cmp.full = &i_vld;

  // Greater-than mask, a run of ones from the head
  assign cmp.cmp  = gt;

endmodule

//--- hdl/book_if.sv
/*
  Book interfaces
  Compare results from the match stage to control, and the
  per-position shift controls from control to the datapath
*/

// Key compare results, one bit per position
interface book_cmp_if import book_pkg::*; ();

  // One-hot equal-key position
  entry_vec_t sel;
  logic       hit;
  logic       full;
  // Valid and stored key above command key
  entry_vec_t cmp;

  modport src (output sel, output hit, output full, output cmp);
  modport dst (input sel, input hit, input full, input cmp);

endinterface

// Shift and insert controls for the payload columns
interface book_shift_if import book_pkg::*; ();

  // Take entry from position i-1 (ADD)
  entry_vec_t take_right;
  // Take entry from position i+1 (DELETE)
  entry_vec_t take_left;
  entry_vec_t ins_key;
  entry_vec_t ins_vol;
  // Column write enable for this edge
  logic       upd;

  modport ctrl (
    output take_right, output take_left, output ins_key, output ins_vol, output upd
  );
  modport col (
    input take_right, input take_left, input ins_key, input ins_vol, input upd
  );
  // Head monitor only needs the head volume source
  modport mon (input take_left, input ins_vol);

endinterface

//--- hdl/book_pkg.sv
/*
  Book package
  Sizes, command encoding and payload types shared by the
  price-ordered book and its testbench
*/
package book_pkg;

  // Book geometry
  localparam int ENTRIES_N   = 8;
  localparam int KEY_BITS    = 16;
  localparam int VOLUME_BITS = 16;
  // Count of valid entries, 0 to ENTRIES_N inclusive
  localparam int LISTSIZE_W  = 4;

  // Command opcodes
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Entry payloads
  typedef logic [KEY_BITS-1:0]    key_t;
  typedef logic [VOLUME_BITS-1:0] volume_t;

  typedef logic [LISTSIZE_W-1:0] listsize_t;

  // One bit per position, bit 0 is the head
  typedef logic [ENTRIES_N-1:0] entry_vec_t;

endpackage
